//--- logic/soc_pkg.sv
`default_nettype none

package soc_pkg;

	localparam int ARCH_BITS = 32;
	// Word addressing drops the byte offset bits
	localparam int ADDR_BITS = ARCH_BITS - $clog2(ARCH_BITS / 8);

	typedef logic [ARCH_BITS-1:0] word_t;
	typedef logic [ADDR_BITS-1:0] waddr_t;
	typedef logic [ARCH_BITS/8-1:0] sel_t;

	// Code 2'b11 was the swap operation and stays reserved
	typedef enum logic [1:0] {
		PI1_NOP = 2'b00,
		PI1_WR  = 2'b01,
		PI1_RD  = 2'b10
	} pi1_op_t;

	typedef struct packed {
		pi1_op_t op;
		waddr_t  addr;
		word_t   data;
		sel_t    sel;
	} pi1_req_t;

	// Slave positions in address order
	typedef enum logic [1:0] {
		DEV_TBL     = 2'd0,
		DEV_GPIO    = 2'd1,
		DEV_IRQ     = 2'd2,
		DEV_INVALID = 2'd3
	} dev_idx_t;

	localparam int DEV_COUNT = 4;
	// Real slaves only, the catch-all is served inside the router
	localparam int SLV_COUNT = DEV_COUNT - 1;

	// Map sizes in words
	localparam int unsigned DEV_MAPSZ [DEV_COUNT] = '{64, 4, 4, 0};
	localparam int unsigned DEV_ID [DEV_COUNT] = '{7, 6, 3, 0};
	localparam bit DEV_USEIRQ [DEV_COUNT] = '{1'b0, 1'b1, 1'b0, 1'b0};

	typedef enum logic [0:0] {
		IRQ_GPIO = 1'b0,
		IRQ_EXT  = 1'b1
	} irq_src_t;

	localparam int IRQ_SRC_COUNT = 2;

	// Reset request register inside the device table
	localparam int DEVTBL_RST_WORD = 63;

	// Byte-lane merge of a bus write into an existing word
	function automatic word_t sel_merge(input word_t old_w, input word_t new_w, input sel_t sel);
		word_t res;
		res = old_w;
		for (int b = 0; b < ARCH_BITS / 8; b++) begin
			if (sel[b])
				res[b*8 +: 8] = new_w[b*8 +: 8];
		end
		return res;
	endfunction

endpackage

`default_nettype wire

//--- logic/reset_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module reset_sequencer #(
	parameter int RST_CNTR_BITS = 20
) (
	 input  wire logic clk_2x_w
	,input  wire logic rst_p
	,input  wire logic rst0_i
	,input  wire logic rst1_i
	,output logic      bus_rst_o
	,output logic      pwroff_o
);

	logic [RST_CNTR_BITS-1:0] cntr_q;
	logic warm_w;
	logic cold_w;
	logic off_w;

	// Request levels from the device table
	assign warm_w = rst1_i && !rst0_i;
	assign cold_w = rst1_i && rst0_i;
	assign off_w  = rst0_i && !rst1_i;

	// Cold has no global reset behind it here and restarts like warm
	always_ff @(posedge clk_2x_w) begin
		if (rst_p || warm_w || cold_w) begin
			cntr_q <= '1;
		end else if (|cntr_q) begin
			cntr_q <= cntr_q - 1'b1;
		end
	end

	// Power-off stays latched until the external reset
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			pwroff_o <= 1'b0;
		end else if (off_w) begin
			pwroff_o <= 1'b1;
		end
	end

	assign bus_rst_o = (|cntr_q) || pwroff_o;

	// Once powered off, the bus is held in reset on every later cycle
	assert property (@(posedge clk_2x_w) disable iff (rst_p)
		pwroff_o |=> pwroff_o && bus_rst_o);

endmodule

`default_nettype wire

//--- logic/pi1_router.sv
`timescale 1ns/10ps
`default_nettype none

module pi1_router (
	 input  wire logic              clk_2x_w
	,input  wire logic              bus_rst_i
	,input  wire soc_pkg::pi1_req_t m_req_i
	,output soc_pkg::word_t         m_data_o
	,output logic                   m_rdy_o
	,output soc_pkg::pi1_req_t      s_req_o [soc_pkg::SLV_COUNT]
	,input  wire soc_pkg::word_t    s_data_i [soc_pkg::SLV_COUNT]
);

	soc_pkg::dev_idx_t sel_w;
	soc_pkg::waddr_t   off_w;
	logic              acc_w;
	soc_pkg::dev_idx_t sel_q;
	logic              rd_q;
	logic [soc_pkg::SLV_COUNT-1:0] act_w;

	// First word of a slave, the sum of all map sizes before it
	function automatic soc_pkg::waddr_t dev_base(input int idx);
		soc_pkg::waddr_t sum;
		sum = '0;
		for (int k = 0; k < idx; k++)
			sum = sum + soc_pkg::waddr_t'(soc_pkg::DEV_MAPSZ[k]);
		return sum;
	endfunction

	assign m_rdy_o = !bus_rst_i;
	assign acc_w   = m_rdy_o && (m_req_i.op != soc_pkg::PI1_NOP);

	// Anything past the last real slave lands on the invalid slave
	always_comb begin
		sel_w = soc_pkg::DEV_INVALID;
		off_w = m_req_i.addr - dev_base(soc_pkg::DEV_INVALID);
		for (int i = 0; i < soc_pkg::SLV_COUNT; i++) begin
			if (m_req_i.addr >= dev_base(i) && m_req_i.addr < dev_base(i + 1)) begin
				sel_w = soc_pkg::dev_idx_t'(i);
				off_w = m_req_i.addr - dev_base(i);
			end
		end
	end

	// Only the selected slave sees a live op
	always_comb begin
		for (int i = 0; i < soc_pkg::SLV_COUNT; i++) begin
			if (acc_w && sel_w == soc_pkg::dev_idx_t'(i))
				s_req_o[i].op = m_req_i.op;
			else
				s_req_o[i].op = soc_pkg::PI1_NOP;
			s_req_o[i].addr = off_w;
			s_req_o[i].data = m_req_i.data;
			s_req_o[i].sel  = m_req_i.sel;
			act_w[i] = (s_req_o[i].op != soc_pkg::PI1_NOP);
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (bus_rst_i) begin
			rd_q  <= 1'b0;
			sel_q <= soc_pkg::DEV_INVALID;
		end else begin
			rd_q <= acc_w && (m_req_i.op == soc_pkg::PI1_RD);
			if (acc_w)
				sel_q <= sel_w;
		end
	end

	// Read return, the invalid slave answers zero and drops writes
	always_comb begin
		m_data_o = '0;
		for (int i = 0; i < soc_pkg::SLV_COUNT; i++) begin
			if (rd_q && sel_q == soc_pkg::dev_idx_t'(i))
				m_data_o = s_data_i[i];
		end
	end

	assert property (@(posedge clk_2x_w) $onehot0(act_w));

	assert property (@(posedge clk_2x_w) disable iff (bus_rst_i)
		m_req_i.op != soc_pkg::pi1_op_t'(2'b11));

endmodule

`default_nettype wire

//--- logic/dev_table.sv
`timescale 1ns/10ps
`default_nettype none

module dev_table (
	 input  wire logic              clk_2x_w
	,input  wire logic              bus_rst_i
	,input  wire soc_pkg::pi1_req_t req_i
	,output soc_pkg::word_t         data_o
	,output logic                   rst0_o
	,output logic                   rst1_o
);

	soc_pkg::word_t rd_word_w;
	logic           wr_rst_w;

	// Two words per device, everything else reads zero
	always_comb begin
		rd_word_w = '0;
		for (int i = 0; i < soc_pkg::DEV_COUNT; i++) begin
			// ID with the interrupt-use flag in the top bit
			if (req_i.addr == soc_pkg::waddr_t'(2 * i)) begin
				rd_word_w = soc_pkg::word_t'(soc_pkg::DEV_ID[i]);
				rd_word_w[soc_pkg::ARCH_BITS-1] = soc_pkg::DEV_USEIRQ[i];
			end
			// Map size in bytes
			if (req_i.addr == soc_pkg::waddr_t'(2 * i + 1)) begin
				rd_word_w = soc_pkg::word_t'(soc_pkg::DEV_MAPSZ[i] * (soc_pkg::ARCH_BITS / 8));
			end
		end
	end

	assign wr_rst_w = (req_i.op == soc_pkg::PI1_WR)
		&& (req_i.addr == soc_pkg::waddr_t'(soc_pkg::DEVTBL_RST_WORD))
		&& req_i.sel[0];

	// Request levels drop again once the bus reset reaches this table
	always_ff @(posedge clk_2x_w) begin
		if (bus_rst_i) begin
			rst0_o <= 1'b0;
			rst1_o <= 1'b0;
		end else if (wr_rst_w) begin
			rst0_o <= req_i.data[0];
			rst1_o <= req_i.data[1];
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (req_i.op == soc_pkg::PI1_RD)
			data_o <= rd_word_w;
	end

endmodule

`default_nettype wire

//--- logic/gpio_port.sv
`timescale 1ns/10ps
`default_nettype none

module gpio_port #(
	parameter int GPIO_COUNT = 8
) (
	 input  wire logic                  clk_2x_w
	,input  wire logic                  bus_rst_i
	,input  wire soc_pkg::pi1_req_t     req_i
	,output soc_pkg::word_t             data_o
	,input  wire logic [GPIO_COUNT-1:0] gp_i
	,output logic [GPIO_COUNT-1:0]      gp_o
	,output logic                       irq_stb_o
	,input  wire logic                  irq_rdy_i
);

	localparam soc_pkg::waddr_t IO_WORD = soc_pkg::waddr_t'(0);
	localparam soc_pkg::waddr_t EN_WORD = soc_pkg::waddr_t'(1);

	logic [GPIO_COUNT-1:0] sync1_q;
	logic [GPIO_COUNT-1:0] sync2_q;
	logic [GPIO_COUNT-1:0] prev_q;
	logic [GPIO_COUNT-1:0] en_q;
	logic [GPIO_COUNT-1:0] change_w;
	logic                  wr_io_w;
	logic                  wr_en_w;
	soc_pkg::word_t        io_wr_w;
	soc_pkg::word_t        en_wr_w;

	assign wr_io_w = (req_i.op == soc_pkg::PI1_WR) && (req_i.addr == IO_WORD);
	assign wr_en_w = (req_i.op == soc_pkg::PI1_WR) && (req_i.addr == EN_WORD);

	// Byte enables apply to both registers
	assign io_wr_w = soc_pkg::sel_merge(soc_pkg::word_t'(gp_o), req_i.data, req_i.sel);
	assign en_wr_w = soc_pkg::sel_merge(soc_pkg::word_t'(en_q), req_i.data, req_i.sel);

	// Two synchronizer stages, then the previous value for edge detect
	always_ff @(posedge clk_2x_w) begin
		sync1_q <= gp_i;
		sync2_q <= sync1_q;
		prev_q  <= sync2_q;
	end

	assign change_w = (sync2_q ^ prev_q) & en_q;

	always_ff @(posedge clk_2x_w) begin
		if (bus_rst_i) begin
			gp_o      <= '0;
			en_q      <= '0;
			irq_stb_o <= 1'b0;
		end else begin
			if (wr_io_w)
				gp_o <= GPIO_COUNT'(io_wr_w);
			if (wr_en_w)
				en_q <= GPIO_COUNT'(en_wr_w);
			// A fresh change wins over an acknowledge in the same cycle
			if (|change_w)
				irq_stb_o <= 1'b1;
			else if (irq_rdy_i)
				irq_stb_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (req_i.op == soc_pkg::PI1_RD) begin
			case (req_i.addr)
				IO_WORD: data_o <= soc_pkg::word_t'(sync2_q);
				EN_WORD: data_o <= soc_pkg::word_t'(en_q);
				default: data_o <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/irq_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module irq_ctrl (
	 input  wire logic                              clk_2x_w
	,input  wire logic                              bus_rst_i
	,input  wire soc_pkg::pi1_req_t                 req_i
	,output soc_pkg::word_t                         data_o
	,input  wire logic [soc_pkg::IRQ_SRC_COUNT-1:0] src_stb_i
	,output logic [soc_pkg::IRQ_SRC_COUNT-1:0]      src_rdy_o
	,output logic                                   dst_stb_o
	,input  wire logic                              dst_rdy_i
);

	logic [soc_pkg::IRQ_SRC_COUNT-1:0] pend_q;
	logic [soc_pkg::IRQ_SRC_COUNT-1:0] low_w;
	logic [soc_pkg::IRQ_SRC_COUNT-1:0] wr_clr_w;
	soc_pkg::word_t                    clr_word_w;
	logic                              wr_w;

	// Lowest-numbered pending source
	assign low_w = pend_q & (~pend_q + 1'b1);

	assign src_rdy_o = dst_rdy_i ? low_w : '0;
	assign dst_stb_o = |pend_q;

	// Software clears pending bits by writing ones to word 0
	assign wr_w       = (req_i.op == soc_pkg::PI1_WR) && (req_i.addr == '0);
	assign clr_word_w = soc_pkg::sel_merge('0, req_i.data, req_i.sel);
	assign wr_clr_w   = wr_w ? clr_word_w[soc_pkg::IRQ_SRC_COUNT-1:0] : '0;

	// The source being acknowledged is not re-latched at the same edge
	always_ff @(posedge clk_2x_w) begin
		if (bus_rst_i) begin
			pend_q <= '0;
		end else begin
			pend_q <= (pend_q & ~src_rdy_o & ~wr_clr_w) | (src_stb_i & ~src_rdy_o);
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (req_i.op == soc_pkg::PI1_RD)
			data_o <= (req_i.addr == '0) ? soc_pkg::word_t'(pend_q) : '0;
	end

	assert property (@(posedge clk_2x_w) disable iff (bus_rst_i)
		$onehot0(src_rdy_o));

endmodule

`default_nettype wire

//--- logic/soc_top.sv
`timescale 1ns/10ps
`default_nettype none

module soc_top #(
	 parameter int GPIO_COUNT    = 8
	,parameter int RST_CNTR_BITS = 20
) (
	 input  wire logic                  clk_2x_w
	,input  wire logic                  rst_p

	// Bus master port, the CPU sits outside
	,input  wire soc_pkg::pi1_req_t     pi1_req_i
	,output soc_pkg::word_t             pi1_data_o
	,output logic                       pi1_rdy_o

	,input  wire logic [GPIO_COUNT-1:0] gp_i
	,output logic [GPIO_COUNT-1:0]      gp_o

	,input  wire logic                  irq_ext_i
	,output logic                       irq_stb_o
	,input  wire logic                  irq_rdy_i

	,output logic                       sys_rst_o
	,output logic                       pwroff_o
);

	soc_pkg::pi1_req_t s_req_w [soc_pkg::SLV_COUNT];
	soc_pkg::word_t    s_data_w [soc_pkg::SLV_COUNT];

	logic rst0_w;
	logic rst1_w;
	logic gpio_stb_w;
	logic [soc_pkg::IRQ_SRC_COUNT-1:0] src_rdy_w;

	// sys_rst_o doubles as the bus reset for every slave
	reset_sequencer #(
		.RST_CNTR_BITS (RST_CNTR_BITS)
	) rst_seq (
		 .clk_2x_w  (clk_2x_w)
		,.rst_p     (rst_p)
		,.rst0_i    (rst0_w)
		,.rst1_i    (rst1_w)
		,.bus_rst_o (sys_rst_o)
		,.pwroff_o  (pwroff_o)
	);

	pi1_router router (
		 .clk_2x_w  (clk_2x_w)
		,.bus_rst_i (sys_rst_o)
		,.m_req_i   (pi1_req_i)
		,.m_data_o  (pi1_data_o)
		,.m_rdy_o   (pi1_rdy_o)
		,.s_req_o   (s_req_w)
		,.s_data_i  (s_data_w)
	);

	dev_table devtbl (
		 .clk_2x_w  (clk_2x_w)
		,.bus_rst_i (sys_rst_o)
		,.req_i     (s_req_w[soc_pkg::DEV_TBL])
		,.data_o    (s_data_w[soc_pkg::DEV_TBL])
		,.rst0_o    (rst0_w)
		,.rst1_o    (rst1_w)
	);

	gpio_port #(
		.GPIO_COUNT (GPIO_COUNT)
	) gpio (
		 .clk_2x_w  (clk_2x_w)
		,.bus_rst_i (sys_rst_o)
		,.req_i     (s_req_w[soc_pkg::DEV_GPIO])
		,.data_o    (s_data_w[soc_pkg::DEV_GPIO])
		,.gp_i      (gp_i)
		,.gp_o      (gp_o)
		,.irq_stb_o (gpio_stb_w)
		,.irq_rdy_i (src_rdy_w[soc_pkg::IRQ_GPIO])
	);

	// Source order follows irq_src_t, the external line is a plain level
	irq_ctrl irqctrl (
		 .clk_2x_w  (clk_2x_w)
		,.bus_rst_i (sys_rst_o)
		,.req_i     (s_req_w[soc_pkg::DEV_IRQ])
		,.data_o    (s_data_w[soc_pkg::DEV_IRQ])
		,.src_stb_i ({irq_ext_i, gpio_stb_w})
		,.src_rdy_o (src_rdy_w)
		,.dst_stb_o (irq_stb_o)
		,.dst_rdy_i (irq_rdy_i)
	);

endmodule

`default_nettype wire

//--- sim/tb_soc.sv
`timescale 1ns/10ps
`default_nettype none

module tb_soc;

	localparam int RST_BITS  = 4;
	localparam int GPIO_BITS = 8;
	// Master-side word addresses
	localparam int GPIO_BASE = 64;
	localparam int IRQ_BASE  = 68;
	localparam int RST_WORD  = 63;
	localparam int BAD_WORD  = 200;
	// All tests together take roughly 400 cycles
	localparam int CYCLE_LIMIT = 2000;

	logic                 clk_2x_w = 1'b0;
	logic                 rst_p;
	soc_pkg::pi1_req_t    pi1_req;
	soc_pkg::word_t       pi1_data;
	logic                 pi1_rdy;
	logic [GPIO_BITS-1:0] gp_in;
	logic [GPIO_BITS-1:0] gp_out;
	logic                 irq_ext;
	logic                 irq_stb;
	logic                 irq_rdy;
	logic                 sys_rst;
	logic                 pwroff;

	int     checks = 0;
	int     errors = 0;
	int     cycles = 0;
	integer seed   = 32'hb941;

	// Device table contents in slave order
	int unsigned exp_id [4]    = '{7, 6, 3, 0};
	bit          exp_irq [4]   = '{1'b0, 1'b1, 1'b0, 1'b0};
	int unsigned exp_words [4] = '{64, 4, 4, 0};

	soc_top #(
		 .GPIO_COUNT    (GPIO_BITS)
		,.RST_CNTR_BITS (RST_BITS)
	) dut0 (
		 .clk_2x_w   (clk_2x_w)
		,.rst_p      (rst_p)
		,.pi1_req_i  (pi1_req)
		,.pi1_data_o (pi1_data)
		,.pi1_rdy_o  (pi1_rdy)
		,.gp_i       (gp_in)
		,.gp_o       (gp_out)
		,.irq_ext_i  (irq_ext)
		,.irq_stb_o  (irq_stb)
		,.irq_rdy_i  (irq_rdy)
		,.sys_rst_o  (sys_rst)
		,.pwroff_o   (pwroff)
	);

	always #20 clk_2x_w = ~clk_2x_w;

	always @(posedge clk_2x_w) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Errors found");
			$finish;
		end
	end

	task automatic check_word(input soc_pkg::word_t got, input soc_pkg::word_t exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_level(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic note_failure(input string what);
		errors++;
		$display("Failure at %0t ns: %s", $time, what);
	endtask

	// Request goes out on one edge, is taken on the next, data follows a cycle later
	task automatic read_word(input int waddr, output soc_pkg::word_t data);
		soc_pkg::pi1_req_t req;
		req.op   = soc_pkg::PI1_RD;
		req.addr = soc_pkg::waddr_t'(waddr);
		req.data = '0;
		req.sel  = 4'hf;
		@(posedge clk_2x_w);
		pi1_req <= req;
		@(posedge clk_2x_w);
		pi1_req.op <= soc_pkg::PI1_NOP;
		@(negedge clk_2x_w);
		data = pi1_data;
	endtask

	task automatic write_word(input int waddr, input soc_pkg::word_t data);
		soc_pkg::pi1_req_t req;
		req.op   = soc_pkg::PI1_WR;
		req.addr = soc_pkg::waddr_t'(waddr);
		req.data = data;
		req.sel  = 4'hf;
		@(posedge clk_2x_w);
		pi1_req <= req;
		@(posedge clk_2x_w);
		pi1_req.op <= soc_pkg::PI1_NOP;
	endtask

	// Counts cycles with the bus reset high, starting at the current falling edge
	task automatic count_reset_cycles(output int n);
		n = 0;
		while (sys_rst && n < 100) begin
			n++;
			@(negedge clk_2x_w);
		end
	endtask

	task automatic reset_countdown;
		int n;
		@(negedge clk_2x_w);
		count_reset_cycles(n);
		check_word(n, 2 ** RST_BITS - 1, "bus reset cycles after rst_p");
		check_level(pi1_rdy, 1'b1, "pi1_rdy_o after count-down");
		check_level(pwroff, 1'b0, "pwroff_o after reset");
		check_level(irq_stb, 1'b0, "irq_stb_o after reset");
		check_word(soc_pkg::word_t'(gp_out), '0, "gp_o after reset");
	endtask

	task automatic read_device_table;
		soc_pkg::word_t got;
		soc_pkg::word_t exp;
		soc_pkg::word_t gp_before;
		for (int i = 0; i < 4; i++) begin
			read_word(2 * i, got);
			exp = {exp_irq[i], 31'(exp_id[i])};
			check_word(got, exp, $sformatf("device %0d ID word", i));
			read_word(2 * i + 1, got);
			check_word(got, exp_words[i] * 4, $sformatf("device %0d map size", i));
		end
		read_word(20, got);
		check_word(got, '0, "unused table word");
		read_word(BAD_WORD, got);
		check_word(got, '0, "invalid address read");
		gp_before = soc_pkg::word_t'(gp_out);
		write_word(BAD_WORD, $random(seed));
		read_word(BAD_WORD, got);
		check_word(got, '0, "invalid address read after write");
		read_word(0, got);
		check_word(got, 32'd7, "device table after invalid write");
		check_word(soc_pkg::word_t'(gp_out), gp_before, "gp_o after invalid write");
		check_level(sys_rst, 1'b0, "sys_rst_o after invalid write");
	endtask

	task automatic gpio_output_follows;
		soc_pkg::word_t val;
		for (int k = 0; k < 8; k++) begin
			val = $random(seed);
			write_word(GPIO_BASE, val);
			@(negedge clk_2x_w);
			check_word(soc_pkg::word_t'(gp_out), val & 32'hff, "gp_o after write");
		end
	endtask

	task automatic gpio_input_sampled;
		soc_pkg::word_t val;
		soc_pkg::word_t got;
		for (int k = 0; k < 8; k++) begin
			val = $random(seed);
			@(posedge clk_2x_w);
			gp_in <= val[GPIO_BITS-1:0];
			// Two synchronizer stages
			repeat (2) @(posedge clk_2x_w);
			read_word(GPIO_BASE, got);
			check_word(got, val & 32'hff, "gp_i read back");
		end
	endtask

	task automatic interrupt_flow;
		soc_pkg::word_t got;
		int bit_idx;
		int n;
		bit_idx = $unsigned($random(seed)) % GPIO_BITS;
		write_word(GPIO_BASE + 1, 32'hff);
		@(negedge clk_2x_w);
		check_level(irq_stb, 1'b0, "irq_stb_o before input change");
		@(posedge clk_2x_w);
		gp_in <= gp_in ^ (GPIO_BITS'(1) << bit_idx);
		n = 0;
		@(negedge clk_2x_w);
		while (!irq_stb && n < 10) begin
			n++;
			@(negedge clk_2x_w);
		end
		check_level(irq_stb, 1'b1, "irq_stb_o after input change");
		if (n > 4)
			note_failure($sformatf("irq_stb_o took %0d cycles to rise, limit is 4", n));
		@(posedge clk_2x_w);
		irq_ext <= 1'b1;
		read_word(IRQ_BASE, got);
		check_word(got, 32'd3, "pending mask with both sources");
		// One acknowledge takes the lowest source, which is GPIO
		@(posedge clk_2x_w);
		irq_rdy <= 1'b1;
		@(posedge clk_2x_w);
		irq_rdy <= 1'b0;
		read_word(IRQ_BASE, got);
		check_word(got, 32'd2, "pending mask after acknowledge");
		check_level(irq_stb, 1'b1, "irq_stb_o with external pending");
		@(posedge clk_2x_w);
		irq_ext <= 1'b0;
		write_word(IRQ_BASE, 32'd2);
		@(negedge clk_2x_w);
		check_level(irq_stb, 1'b0, "irq_stb_o after software clear");
		read_word(IRQ_BASE, got);
		check_word(got, '0, "pending mask after software clear");
	endtask

	task automatic software_reset;
		int n;
		write_word(GPIO_BASE, $random(seed) | 32'h1);
		write_word(RST_WORD, 32'd2);
		n = 0;
		@(negedge clk_2x_w);
		while (!sys_rst && n < 8) begin
			n++;
			@(negedge clk_2x_w);
		end
		if (!sys_rst)
			note_failure("sys_rst_o did not rise after the warm reset request");
		count_reset_cycles(n);
		// One reload cycle while the request level clears, then the count-down
		check_word(n, 1 + 2 ** RST_BITS - 1, "bus reset cycles after warm request");
		check_word(soc_pkg::word_t'(gp_out), '0, "gp_o after warm reset");
		check_level(pwroff, 1'b0, "pwroff_o after warm reset");
		write_word(RST_WORD, 32'd1);
		repeat (20) @(negedge clk_2x_w);
		check_level(pwroff, 1'b1, "pwroff_o after power-off request");
		check_level(sys_rst, 1'b1, "sys_rst_o while powered off");
		check_level(pi1_rdy, 1'b0, "pi1_rdy_o while powered off");
		@(posedge clk_2x_w);
		rst_p <= 1'b1;
		repeat (3) @(posedge clk_2x_w);
		rst_p <= 1'b0;
		@(negedge clk_2x_w);
		count_reset_cycles(n);
		check_word(n, 2 ** RST_BITS - 1, "bus reset cycles after power-off exit");
		check_level(pwroff, 1'b0, "pwroff_o after rst_p pulse");
		check_level(pi1_rdy, 1'b1, "pi1_rdy_o after power-off exit");
	endtask

	initial begin
		rst_p   = 1'b1;
		pi1_req = '0;
		gp_in   = '0;
		irq_ext = 1'b0;
		irq_rdy = 1'b0;
		repeat (3) @(posedge clk_2x_w);
		rst_p <= 1'b0;
		reset_countdown();
		read_device_table();
		gpio_output_follows();
		gpio_input_sampled();
		interrupt_flow();
		software_reset();
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
logic/soc_pkg.sv
logic/reset_sequencer.sv
logic/pi1_router.sv
logic/dev_table.sv
logic/gpio_port.sv
logic/irq_ctrl.sv
logic/soc_top.sv
sim/tb_soc.sv

//--- run_sim.sh
#!/bin/sh
# Build the SoC peripheral testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
	--top-module tb_soc \
	-Mdir "$OBJ" \
	-f filelist.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$OBJ/Vtb_soc" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "No errors" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
